// ==== cache_pkg.sv ====
// shared types for the cache subsystem; one 32-bit word carries four byte lanes
package cache_pkg;

    typedef logic [31:0] word_t;  // data word
    typedef logic [31:0] addr_t;  // byte address
    typedef logic [3:0]  sel_t;   // one select per byte lane
    typedef logic [7:0]  byte_t;  // serial byte

    // cache controller, one host request at a time
    typedef enum logic [2:0] {
        DC_IDLE,
        DC_LOOKUP,
        DC_WRITE,     // write-through in progress
        DC_REFILL0,   // even word of the line
        DC_REFILL1,   // odd word of the line
        DC_RESPOND
    } dcache_state_e;

    typedef enum logic [1:0] {
        LD_COLLECT,   // packing bytes
        LD_WRITE,     // word on the bus
        LD_DONE
    } loader_state_e;

endpackage

// ==== wb_if.sv ====
// wishbone classic, single clock, no err or retry; the slave acks with a one-cycle pulse
interface wb_if import cache_pkg::*; ();

    logic  cyc;    // bus cycle in progress
    logic  stb;
    logic  we;
    addr_t adr;    // byte address
    word_t dat_w;
    word_t dat_r;
    sel_t  sel;
    logic  ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        output sel,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        input  sel,
        output dat_r,
        output ack
    );

endinterface

// ==== uart_rx.sv ====
// 8N1 receiver, line idles high; CLKS_PER_BIT should be 8 or more so samples land inside a bit
module uart_rx import cache_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  w_clk,
    input  logic  arst_n_i,
    input  logic  rxd_i,
    output byte_t byte_o,
    output logic  byte_valid_o
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [1:0]       detect_q;  // consecutive low samples
    logic             busy_q;
    logic [3:0]       bit_q;     // samples taken so far
    logic [CNT_W-1:0] cnt_q;
    logic [8:0]       shift_q;   // stop bit ends up on top
    logic             valid_q;
    logic             detected;
    logic             sample;

    assign detected = &detect_q;
    assign sample   = busy_q && (cnt_q == CNT_W'(CLKS_PER_BIT));

    always_ff @(posedge w_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            detect_q <= '0;
        end else if (rxd_i || busy_q) begin
            detect_q <= '0;
        end else if (!detected) begin
            detect_q <= detect_q + 2'd1;
        end
    end

    always_ff @(posedge w_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            bit_q   <= '0;
            cnt_q   <= CNT_W'(1);
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!busy_q) begin
                bit_q <= '0;
                cnt_q <= CNT_W'(1);
                busy_q <= detected;
            end else if (sample) begin
                cnt_q <= CNT_W'(1);
                bit_q <= bit_q + 4'd1;
                if (bit_q == 4'd8) begin  // stop bit sampled
                    valid_q <= 1'b1;
                    busy_q  <= 1'b0;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (sample) begin
            shift_q <= {rxd_i, shift_q[8:1]};  // lsb first
        end
    end

    assign byte_o       = shift_q[7:0];
    assign byte_valid_o = valid_q;

endmodule

// ==== prog_loader.sv ====
// bytes pack lsb first from address 0 up; a full word must not arrive before the last write acks
module prog_loader import cache_pkg::*; #(
    parameter int LOAD_WORDS = 4
) (
    input  logic  w_clk,
    input  logic  arst_n_i,
    input  byte_t byte_i,
    input  logic  byte_valid_i,
    wb_if.master  bus,
    output logic  load_done_o
);
    localparam int WCNT_W = $clog2(LOAD_WORDS + 1);

    loader_state_e     state_q;
    logic [1:0]        byte_cnt_q;
    logic [WCNT_W-1:0] word_cnt_q;
    addr_t             wr_adr_q;
    word_t             asm_q;       // word being packed
    word_t             wr_dat_q;    // word waiting for its ack
    logic              word_full;

    assign word_full = byte_valid_i && (byte_cnt_q == 2'd3);

    always_ff @(posedge w_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= LD_COLLECT;
            byte_cnt_q <= '0;
            word_cnt_q <= '0;
            wr_adr_q   <= '0;
        end else begin
            if (byte_valid_i && (state_q != LD_DONE)) begin
                byte_cnt_q <= byte_cnt_q + 2'd1;
            end
            case (state_q)
                LD_COLLECT: begin
                    if (word_full) begin
                        state_q <= LD_WRITE;
                    end
                end
                LD_WRITE: begin
                    if (bus.ack) begin
                        wr_adr_q   <= wr_adr_q + 32'd4;
                        word_cnt_q <= word_cnt_q + 1'b1;
                        state_q    <= (word_cnt_q == WCNT_W'(LOAD_WORDS - 1)) ?
                                      LD_DONE : LD_COLLECT;
                    end
                end
                default: ;  // done holds
            endcase
        end
    end

    always_ff @(posedge w_clk) begin
        if (byte_valid_i) begin
            asm_q <= {byte_i, asm_q[31:8]};
        end
        if (word_full && (state_q == LD_COLLECT)) begin
            wr_dat_q <= {byte_i, asm_q[31:8]};
        end
    end

    assign bus.cyc     = (state_q == LD_WRITE);
    assign bus.stb     = (state_q == LD_WRITE);
    assign bus.we      = 1'b1;
    assign bus.adr     = wr_adr_q;
    assign bus.dat_w   = wr_dat_q;
    assign bus.sel     = '1;  // whole words only
    assign load_done_o = (state_q == LD_DONE);

endmodule

// ==== bus_arbiter.sv ====
// two masters, loader wins ties; ownership is granted only from idle and one cycle passes between owners
module bus_arbiter (
    input  logic w_clk,
    input  logic arst_n_i,
    wb_if.slave  m_load,
    wb_if.slave  m_cache,
    wb_if.master mem
);
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_LOAD,
        OWN_CACHE
    } owner_e;

    owner_e owner_q;
    logic   load_sel;
    logic   cache_sel;

    assign load_sel  = (owner_q == OWN_LOAD);
    assign cache_sel = (owner_q == OWN_CACHE);

    always_ff @(posedge w_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= OWN_NONE;
        end else begin
            case (owner_q)
                OWN_NONE: begin
                    if (m_load.cyc) begin
                        owner_q <= OWN_LOAD;
                    end else if (m_cache.cyc) begin
                        owner_q <= OWN_CACHE;
                    end
                end
                OWN_LOAD:  if (!m_load.cyc) owner_q <= OWN_NONE;
                OWN_CACHE: if (!m_cache.cyc) owner_q <= OWN_NONE;
                default:   owner_q <= OWN_NONE;
            endcase
        end
    end

    // owner's request to memory
    assign mem.cyc   = (load_sel && m_load.cyc) || (cache_sel && m_cache.cyc);
    assign mem.stb   = (load_sel && m_load.stb) || (cache_sel && m_cache.stb);
    assign mem.we    = load_sel ? m_load.we : (cache_sel && m_cache.we);
    assign mem.adr   = load_sel ? m_load.adr : m_cache.adr;
    assign mem.dat_w = load_sel ? m_load.dat_w : m_cache.dat_w;
    assign mem.sel   = load_sel ? m_load.sel : m_cache.sel;

    // response back to the owner only
    assign m_load.ack    = load_sel && mem.ack;
    assign m_load.dat_r  = load_sel ? mem.dat_r : '0;
    assign m_cache.ack   = cache_sel && mem.ack;
    assign m_cache.dat_r = cache_sel ? mem.dat_r : '0;

endmodule

// ==== backing_mem.sv ====
// word-aligned accesses only, address wraps at MEM_WORDS; MEM_WORDS a power of two, MEM_LATENCY >= 1
module backing_mem import cache_pkg::*; #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 10
) (
    input  logic w_clk,
    input  logic arst_n_i,
    wb_if.slave  bus
);
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    word_t            mem_q [MEM_WORDS] = '{default: '0};
    word_t            rdata_q;
    logic [CNT_W-1:0] wait_q;   // cycles left to the ack
    logic [IDX_W-1:0] idx;
    logic             take;     // request accepted here

    assign idx  = bus.adr[IDX_W+1:2];
    assign take = bus.cyc && bus.stb && (wait_q == '0);

    always_ff @(posedge w_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_q <= '0;
        end else if (take) begin
            wait_q <= bus.we ? CNT_W'(1) : CNT_W'(MEM_LATENCY);
        end else if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
        end
    end

    always_ff @(posedge w_clk) begin
        if (take) begin
            rdata_q <= mem_q[idx];
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.sel[b]) begin
                        mem_q[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus.ack   = (wait_q == CNT_W'(1));  // one cycle, then idle
    assign bus.dat_r = rdata_q;

endmodule

// ==== dcache.sv ====
// CACHE_LINES a power of two >= 2, host addresses word aligned; host waits until load done
module dcache import cache_pkg::*; #(
    parameter int CACHE_LINES = 8
) (
    input  logic  w_clk,
    input  logic  arst_n_i,
    input  logic  load_done_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  addr_t adr_i,
    input  word_t dat_i,
    input  sel_t  sel_i,
    output word_t dat_o,
    output logic  ack_o,
    wb_if.master  mem
);
    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = 32 - IDX_W - 3;

    dcache_state_e          state_q;
    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    word_t                  line_q [CACHE_LINES][2];
    addr_t                  req_adr_q;
    word_t                  req_dat_q;
    sel_t                   req_sel_q;
    logic                   req_we_q;
    word_t                  fill_q;     // even word until the odd one lands
    word_t                  dat_q;
    logic [IDX_W-1:0]       idx;
    logic [TAG_W-1:0]       tag;
    logic                   wsel;       // word within the line
    logic                   hit;
    logic                   bus_req;
    addr_t                  line_base;

    assign idx       = req_adr_q[IDX_W+2:3];
    assign tag       = req_adr_q[31:IDX_W+3];
    assign wsel      = req_adr_q[2];
    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign line_base = {req_adr_q[31:3], 3'b000};

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_ff @(posedge w_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= DC_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                DC_IDLE: begin
                    if (cyc_i && stb_i && load_done_i) begin
                        state_q <= DC_LOOKUP;
                    end
                end
                DC_LOOKUP: begin
                    if (req_we_q) begin
                        state_q <= DC_WRITE;
                        if (!hit) begin
                            valid_q[idx] <= 1'b0;  // write miss drops the line
                        end
                    end else begin
                        state_q <= hit ? DC_RESPOND : DC_REFILL0;
                    end
                end
                DC_WRITE:   if (mem.ack) state_q <= DC_RESPOND;
                DC_REFILL0: if (mem.ack) state_q <= DC_REFILL1;
                DC_REFILL1: begin
                    if (mem.ack) begin
                        state_q      <= DC_RESPOND;
                        valid_q[idx] <= 1'b1;
                    end
                end
                default: state_q <= DC_IDLE;  // respond lasts one cycle
            endcase
        end
    end

    always_ff @(posedge w_clk) begin
        if (state_q == DC_IDLE) begin  // host holds the request until ack
            req_adr_q <= adr_i;
            req_dat_q <= dat_i;
            req_sel_q <= sel_i;
            req_we_q  <= we_i;
        end
        if (state_q == DC_LOOKUP) begin
            dat_q <= line_q[idx][wsel];
            if (req_we_q && hit) begin
                line_q[idx][wsel] <= merge_bytes(line_q[idx][wsel], req_dat_q, req_sel_q);
            end
        end
        if ((state_q == DC_REFILL0) && mem.ack) begin
            fill_q <= mem.dat_r;
        end
        if ((state_q == DC_REFILL1) && mem.ack) begin
            line_q[idx][0] <= fill_q;
            line_q[idx][1] <= mem.dat_r;
            tag_q[idx]     <= tag;
            dat_q          <= wsel ? mem.dat_r : fill_q;
        end
    end

    // cyc stays up across both refill reads so the arbiter keeps the grant
    assign bus_req   = (state_q == DC_WRITE) || (state_q == DC_REFILL0) ||
                       (state_q == DC_REFILL1);
    assign mem.cyc   = bus_req;
    assign mem.stb   = bus_req;
    assign mem.we    = (state_q == DC_WRITE);
    assign mem.adr   = (state_q == DC_WRITE)   ? req_adr_q :
                       (state_q == DC_REFILL1) ? (line_base | 32'd4) : line_base;
    assign mem.dat_w = req_dat_q;
    assign mem.sel   = (state_q == DC_WRITE) ? req_sel_q : '1;

    assign dat_o = dat_q;
    assign ack_o = (state_q == DC_RESPOND);

endmodule

// ==== cache_sys_top.sv ====
// host port is wishbone classic with word-aligned byte addresses; host requests stall until load done
module cache_sys_top import cache_pkg::*; #(
    parameter int CLKS_PER_BIT = 16,
    parameter int LOAD_WORDS   = 4,
    parameter int MEM_WORDS    = 256,
    parameter int MEM_LATENCY  = 10,
    parameter int CACHE_LINES  = 8
) (
    input  logic  w_clk,
    input  logic  arst_n_i,
    input  logic  rxd_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  addr_t adr_i,
    input  word_t dat_i,
    input  sel_t  sel_i,
    output word_t dat_o,
    output logic  ack_o,
    output logic  load_done_o
);
    byte_t rx_byte;
    logic  rx_valid;

    wb_if ld_bus ();    // loader to arbiter
    wb_if mem_bus ();   // cache to arbiter
    wb_if mem_port ();  // arbiter to memory

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .w_clk        (w_clk),
        .arst_n_i     (arst_n_i),
        .rxd_i        (rxd_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_valid)
    );

    prog_loader #(.LOAD_WORDS(LOAD_WORDS)) u_loader (
        .w_clk        (w_clk),
        .arst_n_i     (arst_n_i),
        .byte_i       (rx_byte),
        .byte_valid_i (rx_valid),
        .bus          (ld_bus.master),
        .load_done_o  (load_done_o)
    );

    bus_arbiter u_arbiter (
        .w_clk    (w_clk),
        .arst_n_i (arst_n_i),
        .m_load   (ld_bus.slave),
        .m_cache  (mem_bus.slave),
        .mem      (mem_port.master)
    );

    backing_mem #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) u_mem (
        .w_clk    (w_clk),
        .arst_n_i (arst_n_i),
        .bus      (mem_port.slave)
    );

    dcache #(.CACHE_LINES(CACHE_LINES)) u_dcache (
        .w_clk       (w_clk),
        .arst_n_i    (arst_n_i),
        .load_done_i (load_done_o),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .sel_i       (sel_i),
        .dat_o       (dat_o),
        .ack_o       (ack_o),
        .mem         (mem_bus.master)
    );

endmodule

// ==== tb_checker.sv ====
// compares host acks against the expected data and latency class set by tb_top before each stb
module tb_checker import cache_pkg::*; #(
    parameter int LOAD_WORDS  = 4,
    parameter int MEM_LATENCY = 10
) (
    input  logic  w_clk,
    input  logic  arst_n_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  logic  ack_i,
    input  word_t dat_i,
    input  logic  load_done_i,
    input  word_t exp_dat_i,
    input  byte_t exp_cls_i,   // H, M or -
    input  int    test_no_i,
    input  int    bytes_sent_i, // bytes put on the serial line so far
    input  logic  final_i,     // end of stimulus
    output int    err_cnt_o,
    output int    pass_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic active;
    int   lat;        // edges since stb first seen
    logic load_seen;
    logic closed;

    initial begin
        active     = 1'b0;
        lat        = 0;
        load_seen  = 1'b0;
        closed     = 1'b0;
        err_cnt_o  = 0;
        pass_cnt_o = 0;
    end

    always @(posedge w_clk) begin : watch
        logic  ok;
        string name;
        ok   = 1'b1;
        name = $sformatf("host_op_%0d", test_no_i);
        if (arst_n_i && load_done_i && !load_seen) begin
            load_seen = 1'b1;
            if (bytes_sent_i != 4 * LOAD_WORDS) begin
                $display("[ERROR] load: expected %0d serial bytes actual %0d",
                         4 * LOAD_WORDS, bytes_sent_i);
                err_cnt_o++;
            end else begin
                $display("[PASS] load: load done raised after %0d serial bytes",
                         bytes_sent_i);
                pass_cnt_o++;
            end
        end
        if (ack_i && !load_done_i) begin
            $display("[ERROR] %s: host ack seen while load done was still low", name);
            err_cnt_o++;
        end
        if (!active && cyc_i && stb_i) begin
            active = 1'b1;
            lat    = 0;
        end else if (active) begin
            lat++;
            if (ack_i) begin
                active = 1'b0;
                if (!we_i && (dat_i !== exp_dat_i)) begin
                    $display("[ERROR] %s data: expected %08h actual %08h",
                             name, exp_dat_i, dat_i);
                    ok = 1'b0;
                end
                if ((exp_cls_i == "H") && (lat != 2)) begin
                    $display("[ERROR] %s latency: expected 2 actual %0d", name, lat);
                    ok = 1'b0;
                end
                if ((exp_cls_i == "M") && (lat <= MEM_LATENCY)) begin
                    $display("[ERROR] %s latency: expected >%0d actual %0d",
                             name, MEM_LATENCY, lat);
                    ok = 1'b0;
                end
                if (ok) begin
                    $display("[PASS] %s %s latency %0d", name, we_i ? "write" : "read", lat);
                    pass_cnt_o++;
                end else begin
                    err_cnt_o++;
                end
            end
        end
        if (final_i && !closed) begin
            closed = 1'b1;
            if (!load_seen) begin
                $display("load done never went high");
                err_cnt_o++;
            end
            $display("summary: %0d passed, %0d failed", pass_cnt_o, err_cnt_o);
        end
    end

endmodule

// ==== tb_top.sv ====
// stimulus from golden_vectors.txt in the project root; host ops start at once and stall until load done
module tb_top import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT = 8;
    localparam int LOAD_WORDS   = 4;
    localparam int MEM_LATENCY  = 10;

    logic  w_clk;
    logic  arst_n_i;
    logic  rxd_i;
    logic  cyc_i;
    logic  stb_i;
    logic  we_i;
    addr_t adr_i;
    word_t dat_i;
    sel_t  sel_i;
    word_t dat_o;
    logic  ack_o;
    logic  load_done_o;

    word_t exp_dat;
    byte_t exp_cls;
    int    test_no;
    int    bytes_sent;
    logic  final_flag;
    int    err_cnt;
    int    pass_cnt;

    byte_t ser_q[$];    // serial bytes in order
    byte_t op_q[$];     // host ops
    addr_t adr_q[$];
    word_t dat_q[$];
    sel_t  sel_q[$];
    word_t exp_q[$];
    byte_t cls_q[$];
    int    cycle_cnt;
    int    cycle_limit;

    cache_sys_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .LOAD_WORDS   (LOAD_WORDS),
        .MEM_WORDS    (256),
        .MEM_LATENCY  (MEM_LATENCY),
        .CACHE_LINES  (8)
    ) uut (
        .w_clk       (w_clk),
        .arst_n_i    (arst_n_i),
        .rxd_i       (rxd_i),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .sel_i       (sel_i),
        .dat_o       (dat_o),
        .ack_o       (ack_o),
        .load_done_o (load_done_o)
    );

    tb_checker #(.LOAD_WORDS(LOAD_WORDS), .MEM_LATENCY(MEM_LATENCY)) chk (
        .w_clk        (w_clk),
        .arst_n_i     (arst_n_i),
        .cyc_i        (cyc_i),
        .stb_i        (stb_i),
        .we_i         (we_i),
        .ack_i        (ack_o),
        .dat_i        (dat_o),
        .load_done_i  (load_done_o),
        .exp_dat_i    (exp_dat),
        .exp_cls_i    (exp_cls),
        .test_no_i    (test_no),
        .bytes_sent_i (bytes_sent),
        .final_i      (final_flag),
        .err_cnt_o    (err_cnt),
        .pass_cnt_o   (pass_cnt)
    );

    function automatic word_t lcg_next(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic read_golden();
        int    fd;
        int    n;
        string line;
        byte_t op;
        byte_t cls;
        word_t a;
        word_t d;
        word_t s;
        word_t e;
        word_t rnd;
        word_t last_rnd;
        rnd      = 32'hf776_b0d1;
        last_rnd = '0;
        fd = $fopen("golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open golden_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if ((line.len() > 1) && (line[0] != "#")) begin
                    n = $sscanf(line, "%c %h %h %h %h %c", op, a, d, s, e, cls);
                    if (op == "S") begin
                        ser_q.push_back(d[7:0]);
                    end else begin
                        if (op == "Q") begin  // random word, full write
                            rnd      = lcg_next(rnd);
                            last_rnd = rnd;
                            d        = rnd;
                        end
                        if (op == "K") begin
                            e = last_rnd;
                        end
                        op_q.push_back(op);
                        adr_q.push_back(a);
                        dat_q.push_back(d);
                        sel_q.push_back(s[3:0]);
                        exp_q.push_back(e);
                        cls_q.push_back(cls);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_byte(byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data, start
        for (int i = 0; i < 10; i++) begin
            rxd_i <= frame[i];
            repeat (CLKS_PER_BIT) @(posedge w_clk);
        end
    endtask

    task automatic host_op(int i);
        logic wr;
        wr = (op_q[i] == "W") || (op_q[i] == "Q");
        @(posedge w_clk);
        cyc_i   <= 1'b1;
        stb_i   <= 1'b1;
        we_i    <= wr;
        adr_i   <= adr_q[i];
        dat_i   <= dat_q[i];
        sel_i   <= sel_q[i];
        exp_dat <= exp_q[i];
        exp_cls <= cls_q[i];
        test_no <= i + 1;
        do @(posedge w_clk); while (!ack_o);
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    initial begin
        w_clk = 1'b0;
        forever #20 w_clk = ~w_clk;
    end

    initial begin
        cycle_cnt = 0;
        while ((cycle_limit == 0) || (cycle_cnt < cycle_limit)) begin
            @(posedge w_clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n_i    = 1'b0;
        rxd_i       = 1'b1;  // line idle
        cyc_i       = 1'b0;
        stb_i       = 1'b0;
        we_i        = 1'b0;
        adr_i       = '0;
        dat_i       = '0;
        sel_i       = '0;
        exp_dat     = '0;
        exp_cls     = "-";
        test_no     = 0;
        bytes_sent  = 0;
        final_flag  = 1'b0;
        cycle_limit = 0;
        read_golden();
        cycle_limit = 2 * (ser_q.size() * 10 * CLKS_PER_BIT +
                      op_q.size() * (2 * MEM_LATENCY + 10)) + 200;
        repeat (8) @(posedge w_clk);
        arst_n_i <= 1'b1;
        @(posedge w_clk);
        fork
            begin
                foreach (ser_q[i]) begin
                    bytes_sent <= bytes_sent + 1;
                    send_byte(ser_q[i]);
                end
            end
            begin
                for (int i = 0; i < op_q.size(); i++) begin
                    host_op(i);
                    @(posedge w_clk);  // idle cycle between ops
                end
            end
        join
        repeat (4) @(posedge w_clk);
        final_flag <= 1'b1;
        repeat (2) @(posedge w_clk);
        if ((err_cnt == 0) && (pass_cnt == op_q.size() + 1)) begin
            $display("TESTS PASSED");
        end else begin
            if (pass_cnt != op_q.size() + 1) begin
                $display("expected %0d passing tests, saw %0d", op_q.size() + 1, pass_cnt);
            end
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
cache_pkg.sv
wb_if.sv
uart_rx.sv
prog_loader.sv
bus_arbiter.sv
backing_mem.sv
dcache.sv
cache_sys_top.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
# Verilator build and run of the cache subsystem testbench

.PHONY: all run build lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_top \
		-o Vtb_top

run: build
	./obj_dir/Vtb_top | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps cache_pkg.sv wb_if.sv uart_rx.sv \
		prog_loader.sv bus_arbiter.sv backing_mem.sv dcache.sv cache_sys_top.sv \
		--top-module cache_sys_top

clean:
	rm -rf obj_dir sim.log

// ==== golden_vectors.txt ====
# op addr data sel expected class; S serial byte (data), R read, W write, Q write of next LCG word
# K read expecting the last LCG word; class H hit (ack 2 cycles after stb), M miss, - none
S 00000000 00000011 0 00000000 -
S 00000000 00000022 0 00000000 -
S 00000000 00000033 0 00000000 -
S 00000000 00000044 0 00000000 -
S 00000000 00000055 0 00000000 -
S 00000000 00000066 0 00000000 -
S 00000000 00000077 0 00000000 -
S 00000000 00000088 0 00000000 -
S 00000000 0000000a 0 00000000 -
S 00000000 0000000b 0 00000000 -
S 00000000 0000000c 0 00000000 -
S 00000000 0000000d 0 00000000 -
S 00000000 000000ef 0 00000000 -
S 00000000 000000be 0 00000000 -
S 00000000 000000ad 0 00000000 -
S 00000000 000000de 0 00000000 -
R 00000000 00000000 f 44332211 M
R 00000004 00000000 f 88776655 H
R 00000008 00000000 f 0d0c0b0a M
R 0000000c 00000000 f deadbeef H
W 00000004 aabbccdd 3 00000000 -
R 00000004 00000000 f 8877ccdd H
R 00000000 00000000 f 44332211 H
W 00000044 12345678 f 00000000 -
R 00000000 00000000 f 44332211 M
R 00000044 00000000 f 12345678 M
Q 00000080 00000000 f 00000000 -
K 00000080 00000000 f 00000000 M
R 00000084 00000000 f 00000000 H
